// ==== design/tpc_pkg.sv ====
// page-table cache shared definitions
package tpc_pkg;

  // sv39 address pieces
  localparam int unsigned VPN_PART_LEN = 9;                // one vpn part, also one tag
  localparam int unsigned VPN_LEN      = 3 * VPN_PART_LEN; // full vpn
  localparam int unsigned PPN_LEN      = 44;               // physical page number
  localparam int unsigned LEVEL_LEN    = 2;                // 0..2 picks vpn0..vpn2

  // configuration port
  localparam int unsigned CSR_DATA_LEN = 16;
  localparam int unsigned CSR_ADDR_LEN = 2;

  // register map
  localparam logic [CSR_ADDR_LEN-1:0] CSR_CTRL   = 2'd0; // bit0 enable, bit1 flush
  localparam logic [CSR_ADDR_LEN-1:0] CSR_HITS   = 2'd1; // hit counter, write clears
  localparam logic [CSR_ADDR_LEN-1:0] CSR_MISSES = 2'd2; // miss counter, write clears

  // bit positions inside CSR_CTRL
  localparam int unsigned CTRL_EN_BIT    = 0;
  localparam int unsigned CTRL_FLUSH_BIT = 1;

  // vpn split into its three parts, vpn2 on top
  typedef struct packed {
    logic [VPN_PART_LEN-1:0] vpn2;
    logic [VPN_PART_LEN-1:0] vpn1;
    logic [VPN_PART_LEN-1:0] vpn0;
  } vpn_parts_t;

  // same vpn word seen flat by the controller and split by the lookup
  typedef union packed {
    logic [VPN_LEN-1:0] flat;
    vpn_parts_t         parts;
  } vpn_u;

endpackage

// ==== design/tpc_regfile.sv ====
// page-table cache entry storage
`timescale 1ns/1ns

module tpc_regfile import tpc_pkg::*; #(
  parameter int unsigned ENTRIES = 8
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      wr_en_i,         // write tag and data of one side
  input  logic                                      wr_part_en_i,    // write the partial bit
  input  logic [VPN_PART_LEN-1:0]                   tag_i,
  input  logic [PPN_LEN-1:0]                        data_i,
  input  logic                                      partial_i,       // mebipage, side 0 only
  input  logic                                      flush_i,         // clears all valid bits
  input  logic [ENTRIES-1:0]                        decoded_waddr_i, // one-hot entry select
  input  logic                                      which_side_i,
  output logic [ENTRIES-1:0][1:0][VPN_PART_LEN-1:0] tag_vec_o,
  output logic [ENTRIES-1:0][1:0][PPN_LEN-1:0]      data_vec_o,
  output logic [ENTRIES-1:0]                        partial_vec_o,
  output logic [ENTRIES-1:0]                        valid_vec_o
);

  localparam int unsigned IDX_LEN = $clog2(ENTRIES);

  logic [IDX_LEN-1:0] write_idx; // encoded write address
  logic               addr_ok;   // some bit of the one-hot is set
  logic               do_write;
  logic               do_part;

  // lowest set bit wins if the address is not really one-hot
  always_comb begin
    write_idx = '0;
    for (int k = ENTRIES-1; k >= 0; k--) begin
      if (decoded_waddr_i[k]) write_idx = IDX_LEN'(k);
    end
  end

  assign addr_ok  = |decoded_waddr_i;
  assign do_write = !flush_i && wr_en_i && addr_ok;                 // flush beats write
  assign do_part  = !flush_i && !wr_en_i && wr_part_en_i && addr_ok; // write beats partial

  // valid and partial bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_vec_o   <= '0;
      partial_vec_o <= '0;
    end else if (flush_i) begin
      valid_vec_o <= '0;
    end else if (do_write) begin
      valid_vec_o[write_idx] <= 1'b1;
    end else if (do_part) begin
      partial_vec_o[write_idx] <= partial_i;
    end
  end

  // tag and ppn array
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      tag_vec_o[write_idx][which_side_i]  <= tag_i;
      data_vec_o[write_idx][which_side_i] <= data_i;
    end
  end

endmodule

// ==== design/tpc_lookup.sv ====
// page-table cache tag compare
`timescale 1ns/1ns

module tpc_lookup import tpc_pkg::*; #(
  parameter int unsigned ENTRIES = 8
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  vpn_u                                      vpn_i,    // latched by the controller
  input  logic [LEVEL_LEN-1:0]                      level_i,
  input  logic                                      enable_i, // 0 forces a miss
  input  logic [ENTRIES-1:0][1:0][VPN_PART_LEN-1:0] tag_vec_i,
  input  logic [ENTRIES-1:0][1:0][PPN_LEN-1:0]      data_vec_i,
  input  logic [ENTRIES-1:0]                        partial_vec_i,
  input  logic [ENTRIES-1:0]                        valid_vec_i,
  output logic                                      hit_o,
  output logic [PPN_LEN-1:0]                        ppn_o
);

  logic [VPN_PART_LEN-1:0] sel_tag; // part picked by the level
  logic [ENTRIES-1:0][1:0] match;   // per side compare result
  logic                    hit_d;
  logic [PPN_LEN-1:0]      ppn_d;

  // level 0 uses vpn0, level 2 uses vpn2
  always_comb begin
    case (level_i)
      2'd1:    sel_tag = vpn_i.parts.vpn1;
      2'd2:    sel_tag = vpn_i.parts.vpn2;
      default: sel_tag = vpn_i.parts.vpn0;
    endcase
  end

  // all sides in parallel
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      match[i][0] = valid_vec_i[i] && (tag_vec_i[i][0] == sel_tag);
      match[i][1] = valid_vec_i[i] && !partial_vec_i[i]   // mebipage has no side 1
                    && (tag_vec_i[i][1] == sel_tag);
    end
  end

  // scan downward so the lowest entry, side 0 first, is the last to win
  always_comb begin
    hit_d = 1'b0;
    ppn_d = '0;
    for (int i = ENTRIES-1; i >= 0; i--) begin
      if (match[i][1]) begin
        hit_d = 1'b1;
        ppn_d = data_vec_i[i][1];
      end
      if (match[i][0]) begin
        hit_d = 1'b1;
        ppn_d = data_vec_i[i][0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_o <= 1'b0;
    end else begin
      hit_o <= hit_d && enable_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ppn_o <= (hit_d && enable_i) ? ppn_d : '0; // miss returns ppn 0
  end

endmodule

// ==== design/tpc_replace.sv ====
// page-table cache victim selection
`timescale 1ns/1ns

module tpc_replace #(
  parameter int unsigned ENTRIES = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [ENTRIES-1:0] valid_vec_i,
  input  logic               alloc_i,        // victim taken, advance the pointer
  output logic [ENTRIES-1:0] victim_onehot_o
);

  localparam int unsigned IDX_LEN = $clog2(ENTRIES);

  logic [IDX_LEN-1:0] ptr_q;      // round-robin pointer
  logic [IDX_LEN-1:0] free_idx;   // lowest invalid entry
  logic [IDX_LEN-1:0] victim_idx;

  always_comb begin
    free_idx = '0;
    for (int k = ENTRIES-1; k >= 0; k--) begin
      if (!valid_vec_i[k]) free_idx = IDX_LEN'(k);
    end
  end

  assign victim_idx      = (&valid_vec_i) ? ptr_q : free_idx; // full cache falls back to rr
  assign victim_onehot_o = ENTRIES'(1) << victim_idx;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (alloc_i) begin
      ptr_q <= (victim_idx == IDX_LEN'(ENTRIES-1)) ? '0 : victim_idx + 1'b1; // wrap
    end
  end

endmodule

// ==== design/tpc_ctrl.sv ====
// page-table cache handshake controller
`timescale 1ns/1ns

module tpc_ctrl import tpc_pkg::*; #(
  parameter int unsigned ENTRIES = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lkp_req_i,
  input  logic [VPN_LEN-1:0]   lkp_vpn_i,
  input  logic [LEVEL_LEN-1:0] lkp_level_i,
  input  logic                 lkp_hit_i,       // registered lookup result
  input  logic [PPN_LEN-1:0]   lkp_ppn_i,
  input  logic                 fill_req_i,
  input  logic                 fill_side_i,
  input  logic                 flush_i,
  input  logic [ENTRIES-1:0]   victim_onehot_i,
  output logic                 lkp_ack_o,
  output logic                 lkp_hit_o,
  output logic [PPN_LEN-1:0]   lkp_ppn_o,
  output vpn_u                 lkp_vpn_o,       // latched vpn to the lookup
  output logic [LEVEL_LEN-1:0] lkp_level_o,
  output logic                 lkp_done_o,      // one pulse per completed lookup
  output logic                 fill_ack_o,
  output logic                 wr_en_o,
  output logic                 wr_part_en_o,
  output logic                 which_side_o,
  output logic [ENTRIES-1:0]   waddr_o,
  output logic                 alloc_o
);

  // state encoding
  localparam logic [2:0] IDLE      = 3'd0;
  localparam logic [2:0] LKP_WAIT  = 3'd1;
  localparam logic [2:0] FILL_WR   = 3'd2;
  localparam logic [2:0] FILL_PART = 3'd3;
  localparam logic [2:0] ACK       = 3'd4;

  logic [2:0]         state_q;
  logic               is_fill_q;  // current op is a fill
  logic               side_q;     // side of the current fill
  logic               fresh_q;    // first ack cycle of a lookup
  logic               hit_q;      // result held through a long ack
  logic [PPN_LEN-1:0] ppn_q;
  logic [ENTRIES-1:0] last_q;     // last allocated entry, one-hot

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      is_fill_q   <= 1'b0;
      side_q      <= 1'b0;
      fresh_q     <= 1'b0;
      hit_q       <= 1'b0;
      ppn_q       <= '0;
      last_q      <= '0;
      lkp_vpn_o   <= '0;
      lkp_level_o <= '0;
    end else begin
      fresh_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (!flush_i && fill_req_i) begin // fill wins the tie
            is_fill_q <= 1'b1;
            side_q    <= fill_side_i;
            state_q   <= FILL_WR;
          end else if (!flush_i && lkp_req_i) begin
            is_fill_q      <= 1'b0;
            lkp_vpn_o.flat <= lkp_vpn_i;
            lkp_level_o    <= lkp_level_i;
            state_q        <= LKP_WAIT;
          end
        end
        LKP_WAIT: begin          // lookup registers its result here
          fresh_q <= 1'b1;
          state_q <= ACK;
        end
        FILL_WR: begin
          if (!side_q) last_q <= victim_onehot_i;
          state_q <= side_q ? ACK : FILL_PART;
        end
        FILL_PART: state_q <= ACK;
        ACK: begin
          if (fresh_q) begin     // freeze the result for the rest of the ack
            hit_q <= lkp_hit_i;
            ppn_q <= lkp_ppn_i;
          end
          if (is_fill_q ? !fill_req_i : !lkp_req_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // handshake outputs
  assign lkp_ack_o  = (state_q == ACK) && !is_fill_q;
  assign fill_ack_o = (state_q == ACK) && is_fill_q;
  assign lkp_hit_o  = fresh_q ? lkp_hit_i : hit_q;
  assign lkp_ppn_o  = fresh_q ? lkp_ppn_i : ppn_q;
  assign lkp_done_o = fresh_q; // counters step in the first ack cycle

  // regfile write sequencing
  assign wr_en_o      = (state_q == FILL_WR);
  assign wr_part_en_o = (state_q == FILL_PART);
  assign which_side_o = side_q;
  assign waddr_o      = (state_q == FILL_WR && !side_q) ? victim_onehot_i : last_q;
  assign alloc_o      = (state_q == FILL_WR) && !side_q && !flush_i; // lost write, keep ptr

endmodule

// ==== design/tpc_csr.sv ====
// page-table cache configuration block
`timescale 1ns/1ns

module tpc_csr import tpc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cfg_req_i,
  input  logic                    cfg_we_i,
  input  logic [CSR_ADDR_LEN-1:0] cfg_addr_i,
  input  logic [CSR_DATA_LEN-1:0] cfg_wdata_i,
  input  logic                    lkp_done_i, // a lookup just completed
  input  logic                    lkp_hit_i,
  output logic                    cfg_ack_o,
  output logic [CSR_DATA_LEN-1:0] cfg_rdata_o,
  output logic                    enable_o,
  output logic                    flush_o     // one-cycle pulse
);

  logic                    accept;  // request seen, ack not yet up
  logic                    wr_acc;
  logic [CSR_DATA_LEN-1:0] hits_q;
  logic [CSR_DATA_LEN-1:0] misses_q;
  logic [CSR_DATA_LEN-1:0] rdata_d;

  assign accept  = cfg_req_i && !cfg_ack_o;
  assign wr_acc  = accept && cfg_we_i;
  assign flush_o = wr_acc && (cfg_addr_i == CSR_CTRL) && cfg_wdata_i[CTRL_FLUSH_BIT];

  // read mux, flush bit always reads 0
  always_comb begin
    case (cfg_addr_i)
      CSR_CTRL:   rdata_d = CSR_DATA_LEN'(enable_o);
      CSR_HITS:   rdata_d = hits_q;
      CSR_MISSES: rdata_d = misses_q;
      default:    rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_ack_o <= 1'b0;
      enable_o  <= 1'b0;
      hits_q    <= '0;
      misses_q  <= '0;
    end else begin
      if (accept) cfg_ack_o <= 1'b1;
      else if (!cfg_req_i) cfg_ack_o <= 1'b0; // drop one cycle after req
      if (wr_acc && cfg_addr_i == CSR_CTRL) enable_o <= cfg_wdata_i[CTRL_EN_BIT];
      // a write clears, else count with saturation
      if (wr_acc && cfg_addr_i == CSR_HITS) begin
        hits_q <= '0;
      end else if (lkp_done_i && lkp_hit_i && !(&hits_q)) begin
        hits_q <= hits_q + 1'b1;
      end
      if (wr_acc && cfg_addr_i == CSR_MISSES) begin
        misses_q <= '0;
      end else if (lkp_done_i && !lkp_hit_i && !(&misses_q)) begin
        misses_q <= misses_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) cfg_rdata_o <= rdata_d; // held for the whole ack
  end

endmodule

// ==== design/tpc_top.sv ====
// page-table cache top level
`timescale 1ns/1ns

module tpc_top import tpc_pkg::*; #(
  parameter int unsigned ENTRIES = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // lookup port
  input  logic                    lkp_req_i,
  input  logic [VPN_LEN-1:0]      lkp_vpn_i,
  input  logic [LEVEL_LEN-1:0]    lkp_level_i,
  output logic                    lkp_ack_o,
  output logic                    lkp_hit_o,
  output logic [PPN_LEN-1:0]      lkp_ppn_o,
  // fill port from the walker
  input  logic                    fill_req_i,
  input  logic [VPN_PART_LEN-1:0] fill_tag_i,
  input  logic [PPN_LEN-1:0]      fill_ppn_i,
  input  logic                    fill_side_i,
  input  logic                    fill_partial_i,
  output logic                    fill_ack_o,
  // configuration port
  input  logic                    cfg_req_i,
  input  logic                    cfg_we_i,
  input  logic [CSR_ADDR_LEN-1:0] cfg_addr_i,
  input  logic [CSR_DATA_LEN-1:0] cfg_wdata_i,
  output logic                    cfg_ack_o,
  output logic [CSR_DATA_LEN-1:0] cfg_rdata_o
);

  logic                                      wr_en, wr_part_en, which_side, alloc;
  logic [ENTRIES-1:0]                        waddr, victim_onehot;
  logic [ENTRIES-1:0][1:0][VPN_PART_LEN-1:0] tag_vec;
  logic [ENTRIES-1:0][1:0][PPN_LEN-1:0]      data_vec;
  logic [ENTRIES-1:0]                        partial_vec, valid_vec;
  vpn_u                                      lkp_vpn;      // latched lookup vpn
  logic [LEVEL_LEN-1:0]                      lkp_level;
  logic                                      res_hit;      // lookup register output
  logic [PPN_LEN-1:0]                        res_ppn;
  logic                                      lkp_done, enable, flush;

  tpc_ctrl #(.ENTRIES(ENTRIES)) u_ctrl (
    .clk_i, .rst_ni, .lkp_req_i, .lkp_vpn_i, .lkp_level_i,
    .lkp_hit_i(res_hit), .lkp_ppn_i(res_ppn),
    .fill_req_i, .fill_side_i, .flush_i(flush), .victim_onehot_i(victim_onehot),
    .lkp_ack_o, .lkp_hit_o, .lkp_ppn_o,
    .lkp_vpn_o(lkp_vpn), .lkp_level_o(lkp_level), .lkp_done_o(lkp_done),
    .fill_ack_o, .wr_en_o(wr_en), .wr_part_en_o(wr_part_en),
    .which_side_o(which_side), .waddr_o(waddr), .alloc_o(alloc)
  );

  // fill payload goes straight from the port, held by the handshake
  tpc_regfile #(.ENTRIES(ENTRIES)) u_regfile (
    .clk_i, .rst_ni, .wr_en_i(wr_en), .wr_part_en_i(wr_part_en),
    .tag_i(fill_tag_i), .data_i(fill_ppn_i), .partial_i(fill_partial_i),
    .flush_i(flush), .decoded_waddr_i(waddr), .which_side_i(which_side),
    .tag_vec_o(tag_vec), .data_vec_o(data_vec),
    .partial_vec_o(partial_vec), .valid_vec_o(valid_vec)
  );

  tpc_lookup #(.ENTRIES(ENTRIES)) u_lookup (
    .clk_i, .rst_ni, .vpn_i(lkp_vpn), .level_i(lkp_level), .enable_i(enable),
    .tag_vec_i(tag_vec), .data_vec_i(data_vec),
    .partial_vec_i(partial_vec), .valid_vec_i(valid_vec),
    .hit_o(res_hit), .ppn_o(res_ppn)
  );

  tpc_replace #(.ENTRIES(ENTRIES)) u_replace (
    .clk_i, .rst_ni, .valid_vec_i(valid_vec), .alloc_i(alloc),
    .victim_onehot_o(victim_onehot)
  );

  // counters see the held hit, one pulse per lookup
  tpc_csr u_csr (
    .clk_i, .rst_ni, .cfg_req_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .lkp_done_i(lkp_done), .lkp_hit_i(lkp_hit_o),
    .cfg_ack_o, .cfg_rdata_o, .enable_o(enable), .flush_o(flush)
  );

endmodule

// ==== tb/tpc_ref.svh ====
// page-table cache reference model
`ifndef TPC_REF_SVH
`define TPC_REF_SVH

logic [VPN_PART_LEN-1:0] m_tag     [ENTRIES][2]; // side 1 keeps stale data until rewritten
logic [PPN_LEN-1:0]      m_ppn     [ENTRIES][2];
bit                      m_partial [ENTRIES];
bit                      m_valid   [ENTRIES];
int                      m_ptr    = 0; // round-robin pointer
int                      m_last   = 0; // entry of the latest side-0 fill
bit                      m_enable = 1'b0;
int                      m_hits   = 0;
int                      m_misses = 0;

// lowest invalid entry, else the pointer
function automatic int ref_victim();
  for (int i = 0; i < ENTRIES; i++) begin
    if (!m_valid[i]) return i;
  end
  return m_ptr;
endfunction

// returns {hit, ppn}
function automatic logic [PPN_LEN:0] ref_lookup(input logic [VPN_LEN-1:0] vpn, input int level);
  logic [VPN_PART_LEN-1:0] want;
  want = vpn[level*VPN_PART_LEN +: VPN_PART_LEN]; // level 0 is the low part
  if (!m_enable) return '0;
  for (int i = 0; i < ENTRIES; i++) begin
    if (m_valid[i] && m_tag[i][0] == want) return {1'b1, m_ppn[i][0]};
    if (m_valid[i] && !m_partial[i] && m_tag[i][1] == want) return {1'b1, m_ppn[i][1]};
  end
  return '0;
endfunction

function automatic void model_fill(input bit side, input logic [VPN_PART_LEN-1:0] tag,
                                   input logic [PPN_LEN-1:0] ppn, input bit partial);
  int v;
  if (side) begin // second half of the last allocation
    m_tag[m_last][1] = tag;
    m_ppn[m_last][1] = ppn;
    return;
  end
  v = ref_victim();
  m_tag[v][0]  = tag;
  m_ppn[v][0]  = ppn;
  m_partial[v] = partial;
  m_valid[v]   = 1'b1;
  m_last       = v;
  m_ptr        = (v + 1) % ENTRIES;
endfunction

function automatic void model_flush();
  for (int i = 0; i < ENTRIES; i++) m_valid[i] = 1'b0; // pointer untouched
endfunction

`endif

// ==== tb/tpc_tb.sv ====
// page-table cache testbench
`timescale 1ns/1ns

module tpc_tb import tpc_pkg::*; ();

  localparam int unsigned ENTRIES = 8;
  localparam int N_LKP      = 24;                           // lookups per random batch
  localparam int N_OPS      = 6*ENTRIES + 3*N_LKP + 43;     // handshakes in the sequence
  localparam int MAX_CYCLES = 40*N_OPS + 200;
  localparam int HS_LIMIT   = 200;                          // cycles for one ack edge

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    lkp_req, lkp_ack, lkp_hit;
  logic [VPN_LEN-1:0]      lkp_vpn;
  logic [LEVEL_LEN-1:0]    lkp_level;
  logic [PPN_LEN-1:0]      lkp_ppn;
  logic                    fill_req, fill_side, fill_partial, fill_ack;
  logic [VPN_PART_LEN-1:0] fill_tag;
  logic [PPN_LEN-1:0]      fill_ppn;
  logic                    cfg_req, cfg_we, cfg_ack;
  logic [CSR_ADDR_LEN-1:0] cfg_addr;
  logic [CSR_DATA_LEN-1:0] cfg_wdata, cfg_rdata;

  int                      seed   = 77567;
  int                      errors = 0;
  int                      cycles = 0;
  logic [VPN_PART_LEN-1:0] tag_hist [$];   // every tag ever filled
  logic                    exp_hit;
  logic [PPN_LEN-1:0]      exp_ppn;
  logic [CSR_DATA_LEN-1:0] exp_rdata;
  bit                      cfg_check = 1'b0; // current config access is a read
  logic                    lkp_ack_q = 1'b0;
  logic                    fill_ack_q = 1'b0;
  logic                    cfg_ack_q = 1'b0;
  time                     lkp_rise_t;
  time                     lkp_drop_t;       // lookup req taken low
  time                     fill_rise_t;
  logic [VPN_PART_LEN-1:0] new_tag;
  logic [VPN_LEN-1:0]      new_vpn;

  `include "tpc_ref.svh"

  tpc_top #(.ENTRIES(ENTRIES)) UUT (
    .clk_i, .rst_ni,
    .lkp_req_i(lkp_req), .lkp_vpn_i(lkp_vpn), .lkp_level_i(lkp_level),
    .lkp_ack_o(lkp_ack), .lkp_hit_o(lkp_hit), .lkp_ppn_o(lkp_ppn),
    .fill_req_i(fill_req), .fill_tag_i(fill_tag), .fill_ppn_i(fill_ppn),
    .fill_side_i(fill_side), .fill_partial_i(fill_partial), .fill_ack_o(fill_ack),
    .cfg_req_i(cfg_req), .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
    .cfg_ack_o(cfg_ack), .cfg_rdata_o(cfg_rdata)
  );

  always #10 clk_i = ~clk_i; // 20 ns period

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles, errors: %0d", MAX_CYCLES, errors);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic ack_of(input int port);
    case (port)
      0:       return lkp_ack;
      1:       return fill_ack;
      default: return cfg_ack;
    endcase
  endfunction

  task automatic await_ack(input int port, input logic want, input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (ack_of(port) !== want && n < HS_LIMIT);
    if (ack_of(port) !== want) begin
      errors++;
      $display("%0t: %s ack never went to %0d, handshake stuck", $time, what, want);
    end
  endtask

  // four phases on the lookup port, req held hold extra cycles after ack
  task automatic do_lookup(input logic [VPN_LEN-1:0] vpn, input logic [LEVEL_LEN-1:0] level,
                           input int hold);
    logic [PPN_LEN:0] r;
    @(posedge clk_i);
    r       = ref_lookup(vpn, int'(level));
    exp_hit = r[PPN_LEN];
    exp_ppn = r[PPN_LEN-1:0];
    if (r[PPN_LEN] && m_hits < 65535) m_hits++;
    if (!r[PPN_LEN] && m_misses < 65535) m_misses++;
    lkp_vpn   <= vpn;
    lkp_level <= level;
    lkp_req   <= 1'b1;
    await_ack(0, 1'b1, "lookup");
    repeat (hold) @(posedge clk_i);
    lkp_req    <= 1'b0;
    lkp_drop_t = $time;
    await_ack(0, 1'b0, "lookup");
  endtask

  task automatic do_fill(input bit side, input logic [VPN_PART_LEN-1:0] tag,
                         input logic [PPN_LEN-1:0] ppn, input bit partial);
    model_fill(side, tag, ppn, partial); // before the first edge, see concurrent case
    tag_hist.push_back(tag);
    @(posedge clk_i);
    fill_side    <= side;
    fill_tag     <= tag;
    fill_ppn     <= ppn;
    fill_partial <= partial;
    fill_req     <= 1'b1;
    await_ack(1, 1'b1, "fill");
    fill_req <= 1'b0;
    await_ack(1, 1'b0, "fill");
  endtask

  task automatic cfg_access(input bit we, input logic [CSR_ADDR_LEN-1:0] addr,
                            input logic [CSR_DATA_LEN-1:0] wdata,
                            input logic [CSR_DATA_LEN-1:0] rd_exp);
    @(posedge clk_i);
    cfg_check = !we;
    exp_rdata = rd_exp;
    cfg_we    <= we;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    cfg_req   <= 1'b1;
    await_ack(2, 1'b1, "config");
    cfg_req <= 1'b0;
    await_ack(2, 1'b0, "config");
  endtask

  task automatic cfg_write(input logic [CSR_ADDR_LEN-1:0] addr,
                           input logic [CSR_DATA_LEN-1:0] data);
    if (addr == CSR_CTRL) begin
      m_enable = data[CTRL_EN_BIT];
      if (data[CTRL_FLUSH_BIT]) model_flush();
    end else if (addr == CSR_HITS) begin
      m_hits = 0;
    end else if (addr == CSR_MISSES) begin
      m_misses = 0;
    end
    cfg_access(1'b1, addr, data, '0);
  endtask

  task automatic cfg_read(input logic [CSR_ADDR_LEN-1:0] addr,
                          input logic [CSR_DATA_LEN-1:0] rd_exp);
    cfg_access(1'b0, addr, '0, rd_exp);
  endtask

  function automatic logic [VPN_PART_LEN-1:0] rand_tag();
    return VPN_PART_LEN'($random(seed) & 31); // small pool, so tags collide
  endfunction

  function automatic logic [PPN_LEN-1:0] rand_ppn();
    return PPN_LEN'({$random(seed), $random(seed)});
  endfunction

  // mostly a known tag at the chosen level, sometimes fully random
  function automatic logic [VPN_LEN-1:0] pick_vpn(input int level);
    logic [VPN_LEN-1:0] v;
    v = VPN_LEN'($random(seed));
    if (tag_hist.size() > 0 && ($random(seed) & 3) != 0)
      v[level*VPN_PART_LEN +: VPN_PART_LEN] = tag_hist[$unsigned($random(seed)) % tag_hist.size()];
    return v;
  endfunction

  task automatic lookup_batch(input int n);
    int level;
    repeat (n) begin
      level = $unsigned($random(seed)) % 3;
      do_lookup(pick_vpn(level), LEVEL_LEN'(level), 0);
    end
  endtask

  task automatic fill_batch(input int n);
    repeat (n) begin
      do_fill(1'b0, rand_tag(), rand_ppn(), 1'($random(seed)));
      do_fill(1'b1, rand_tag(), rand_ppn(), 1'b0);
    end
  endtask

  // compare process, lookup result checked on every ack cycle
  always @(posedge clk_i) begin
    if (lkp_ack && !lkp_ack_q) lkp_rise_t = $time;
    if (lkp_ack && lkp_hit !== exp_hit) begin
      errors++;
      $display("Mismatch at %0t: lkp_hit_o expected %0d got %0d", $time, exp_hit, lkp_hit);
    end
    if (lkp_ack && lkp_ppn !== exp_ppn) begin
      errors++;
      $display("Mismatch at %0t: lkp_ppn_o expected %h got %h", $time, exp_ppn, lkp_ppn);
    end
    if (fill_ack && !fill_ack_q) fill_rise_t = $time;
    if (cfg_ack && !cfg_ack_q && cfg_check && cfg_rdata !== exp_rdata) begin
      errors++;
      $display("Mismatch at %0t: cfg_rdata_o expected %h got %h", $time, exp_rdata, cfg_rdata);
    end
    if (lkp_ack && fill_ack) begin
      errors++;
      $display("%0t: lookup and fill acks were high in the same cycle", $time);
    end
    if ((lkp_ack_q && !lkp_ack && lkp_req) || (fill_ack_q && !fill_ack && fill_req)) begin
      errors++;
      $display("%0t: an ack dropped while its request was still high", $time);
    end
    lkp_ack_q  <= lkp_ack;
    fill_ack_q <= fill_ack;
    cfg_ack_q  <= cfg_ack;
  end

  initial begin
    lkp_req      = 1'b0;
    lkp_vpn      = '0;
    lkp_level    = '0;
    fill_req     = 1'b0;
    fill_side    = 1'b0;
    fill_partial = 1'b0;
    fill_tag     = '0;
    fill_ppn     = '0;
    cfg_req      = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    rst_ni       = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    cfg_read(CSR_CTRL, 16'd0);         // disabled out of reset
    do_lookup(pick_vpn(0), 2'd0, 0);
    cfg_read(CSR_MISSES, 16'd1);
    cfg_write(CSR_CTRL, 16'h0001);
    fill_batch(ENTRIES - 2);           // leaves two entries free
    lookup_batch(N_LKP);
    fill_batch(ENTRIES + 4);           // evictions by round-robin
    lookup_batch(N_LKP);
    cfg_write(CSR_CTRL, 16'h0000);     // disabled, a stored tag must miss
    do_lookup(VPN_LEN'(m_tag[0][0]), 2'd0, 0);
    cfg_write(CSR_CTRL, 16'h0003);     // flush and enable again
    cfg_read(CSR_CTRL, 16'd1);         // flush bit reads back 0
    lookup_batch(8);
    fill_batch(ENTRIES + 1);
    lookup_batch(N_LKP);
    cfg_read(CSR_HITS, 16'(m_hits));
    cfg_read(CSR_MISSES, 16'(m_misses));
    cfg_write(CSR_HITS, 16'hffff);
    cfg_read(CSR_HITS, 16'd0);
    lookup_batch(4);
    cfg_read(CSR_HITS, 16'(m_hits));
    cfg_write(CSR_MISSES, 16'd0);
    cfg_read(CSR_MISSES, 16'd0);
    // fill and lookup raised in the same cycle
    new_tag = rand_tag();
    new_vpn = VPN_LEN'($random(seed));
    new_vpn[VPN_PART_LEN-1:0] = new_tag;
    fork
      do_fill(1'b0, new_tag, rand_ppn(), 1'b0);
      do_lookup(new_vpn, 2'd0, 0);
    join
    if (!(fill_rise_t < lkp_rise_t)) begin
      errors++;
      $display("%0t: the fill was not acked before the concurrent lookup", $time);
    end
    // lookup holds req after ack, fill must wait
    fork
      do_lookup(pick_vpn(1), 2'd1, 8);
      begin
        repeat (3) @(posedge clk_i);
        do_fill(1'b0, rand_tag(), rand_ppn(), 1'b1);
      end
    join
    if (!(fill_rise_t > lkp_drop_t)) begin
      errors++;
      $display("%0t: the fill was acked while the lookup still held its request", $time);
    end
    lookup_batch(4);
    cfg_read(CSR_HITS, 16'(m_hits));
    cfg_read(CSR_MISSES, 16'(m_misses));
    $display("checks done after %0d cycles, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+tb
design/tpc_pkg.sv
design/tpc_regfile.sv
design/tpc_lookup.sv
design/tpc_replace.sv
design/tpc_ctrl.sv
design/tpc_csr.sv
design/tpc_top.sv
tb/tpc_tb.sv
